//--- hdl/aes_consts.svh
// widths, round count and gf(2^8) constants of the aes-128 encipher core
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// datapath widths
`define AES_BLOCK_W     128     // state and cipher key
`define AES_WORD_W      32      // one column
`define AES_BYTE_W      8       // one field element
`define AES_NUM_WORDS   4       // columns per block

// cipher constants
`define AES_NUM_ROUNDS  10      // 128-bit key
`define AES_GF_POLY     8'h1b   // x^8 + x^4 + x^3 + x + 1, low byte
`define AES_SBOX_AFFINE 8'h63   // affine offset of the sbox
`define AES_RCON_INIT   8'h01   // rcon of round 1

`endif

//--- hdl/aes_data_pkg.sv
// vector types for block, column, byte and round number
// plus the gf(2^8) doubling shared by sbox, mix columns and rcon
`include "aes_consts.svh"

package aes_data_pkg;

    typedef logic [`AES_BLOCK_W-1:0] aes_block_t;   // state, key, round key
    typedef logic [`AES_WORD_W-1:0]  aes_word_t;    // one column
    typedef logic [`AES_BYTE_W-1:0]  aes_byte_t;    // field element
    typedef logic [3:0]              aes_round_t;   // round 1..10

    // multiply by x modulo the field polynomial
    function automatic aes_byte_t gf_xtime(input aes_byte_t b);
        aes_byte_t red;
        red = b[`AES_BYTE_W-1] ? aes_byte_t'(`AES_GF_POLY) : '0;  // reduce on carry out
        return {b[`AES_BYTE_W-2:0], 1'b0} ^ red;
    endfunction

endpackage

//--- hdl/aes_ctrl_pkg.sv
// sequencer state encoding and column index type
`include "aes_consts.svh"

package aes_ctrl_pkg;

    // round sequencer states
    typedef enum logic [1:0] {
        IDLE,   // waiting for req
        SUB,    // one column through the sbox per cycle
        ADD,    // shift rows, mix columns, add round key
        DONE    // ack high until req drops
    } seq_state_t;

    // column index, 0 is the msb column
    typedef logic [$clog2(`AES_NUM_WORDS)-1:0] col_sel_t;

endpackage

//--- hdl/aes_sbox_word.sv
// four parallel sbox lookups on one 32-bit word
// table built at elaboration from field inverse and affine map
`timescale 1ns/1ns
`include "aes_consts.svh"

module aes_sbox_word (
    input  aes_data_pkg::aes_word_t word_in,
    output aes_data_pkg::aes_word_t word_out
);
    import aes_data_pkg::*;

    localparam int TBL_SIZE = 2 ** `AES_BYTE_W;
    localparam int NUM_BYTES = `AES_WORD_W / `AES_BYTE_W;

    aes_byte_t sbox_tbl [TBL_SIZE];     // constant rom

    // shift and add multiply in gf(2^8)
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t sh;
        acc = '0;
        sh = a;
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;             // add partial product
            end
            sh = gf_xtime(sh);
        end
        return acc;
    endfunction

    // inverse as x^254, then affine transform
    function automatic aes_byte_t sbox_calc(input int unsigned x);
        aes_byte_t base;
        aes_byte_t inv;
        aes_byte_t pow_bits;
        aes_byte_t rot;
        aes_byte_t res;
        base = aes_byte_t'(x);
        inv = 8'h01;
        pow_bits = 8'hfe;                   // 254, zero maps to zero
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            if (pow_bits[i]) begin
                inv = gf_mul(inv, base);
            end
            base = gf_mul(base, base);      // square for next bit
        end
        res = inv;
        rot = inv;
        for (int k = 0; k < 4; k++) begin
            rot = {rot[`AES_BYTE_W-2:0], rot[`AES_BYTE_W-1]};  // rotl by k+1
            res = res ^ rot;
        end
        return res ^ aes_byte_t'(`AES_SBOX_AFFINE);
    endfunction

    // every entry is an elaboration constant
    for (genvar v = 0; v < TBL_SIZE; v++) begin : g_tbl
        localparam aes_byte_t ENTRY = sbox_calc(v);
        assign sbox_tbl[v] = ENTRY;
    end

    // byte-wise lookup
    for (genvar b = 0; b < NUM_BYTES; b++) begin : g_lut
        assign word_out[b*`AES_BYTE_W +: `AES_BYTE_W] =
            sbox_tbl[word_in[b*`AES_BYTE_W +: `AES_BYTE_W]];
    end

endmodule

//--- hdl/aes_key_schedule.sv
// on-the-fly aes-128 key expansion
// round key register, rcon register and next-key logic
`timescale 1ns/1ns
`include "aes_consts.svh"

module aes_key_schedule (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  aes_data_pkg::aes_block_t key,
    input  logic                     key_step,
    output aes_data_pkg::aes_block_t round_key
);
    import aes_data_pkg::*;

    aes_block_t key_q;                      // current round key
    aes_byte_t  rcon_q;                     // round constant
    aes_word_t  sub_last;                   // sbox of last key word
    aes_word_t  temp;                       // rot, sub, rcon term
    aes_word_t  w_old [`AES_NUM_WORDS];
    aes_word_t  w_new [`AES_NUM_WORDS];

    // second sbox, dedicated to the key path
    aes_sbox_word u_sbox (
        .word_in  (key_q[`AES_WORD_W-1:0]),
        .word_out (sub_last)
    );

    always_comb begin
        {w_old[0], w_old[1], w_old[2], w_old[3]} = key_q;
        // rotword after subword, same bytes either order
        temp = {sub_last[`AES_WORD_W-`AES_BYTE_W-1:0], sub_last[`AES_WORD_W-1 -: `AES_BYTE_W]}
             ^ {rcon_q, {(`AES_WORD_W-`AES_BYTE_W){1'b0}}};
        w_new[0] = w_old[0] ^ temp;
        for (int i = 1; i < `AES_NUM_WORDS; i++) begin
            w_new[i] = w_old[i] ^ w_new[i-1];   // chained xor
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q  <= '0;
            rcon_q <= '0;
        end else if (load) begin
            key_q  <= key;                  // round 0 key
            rcon_q <= aes_byte_t'(`AES_RCON_INIT);
        end else if (key_step) begin
            key_q  <= {w_new[0], w_new[1], w_new[2], w_new[3]};
            rcon_q <= gf_xtime(rcon_q);     // rcon doubling
        end
    end

    assign round_key = key_q;               // after round 10, the decipher key

endmodule

//--- hdl/aes_round_datapath.sv
// aes state register and round transforms
// column-serial sub bytes, shift rows, mix columns, add round key
`timescale 1ns/1ns
`include "aes_consts.svh"

module aes_round_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  aes_data_pkg::aes_block_t plaintext,
    input  aes_data_pkg::aes_block_t key,
    input  logic                     sub_en,
    input  aes_ctrl_pkg::col_sel_t   col_sel,
    input  logic                     add_en,
    input  logic                     final_round,
    input  aes_data_pkg::aes_block_t round_key,
    output aes_data_pkg::aes_block_t state
);
    import aes_data_pkg::*;

    aes_block_t state_q;                    // iterated state, also the result
    logic [$clog2(`AES_BLOCK_W)-1:0] col_base;  // lsb of selected column
    aes_word_t  col_sub;                    // substituted column
    aes_block_t shifted;
    aes_block_t mixed;
    aes_block_t add_in;                     // mixed, or shifted in last round

    // byte k of the block sits at [127-8k -: 8], column-major
    function automatic aes_block_t shift_rows(input aes_block_t s);
        aes_block_t r;
        int src;
        for (int c = 0; c < `AES_NUM_WORDS; c++) begin
            for (int row = 0; row < 4; row++) begin
                src = 4 * ((c + row) % 4) + row;    // row r rotates left by r
                r[`AES_BLOCK_W-1 - `AES_BYTE_W*(4*c+row) -: `AES_BYTE_W] =
                    s[`AES_BLOCK_W-1 - `AES_BYTE_W*src -: `AES_BYTE_W];
            end
        end
        return r;
    endfunction

    // one column times the fixed {02 03 01 01} circulant
    function automatic aes_word_t mix_word(input aes_word_t w);
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        {a0, a1, a2, a3} = w;
        return {gf_xtime(a0) ^ gf_xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ gf_xtime(a1) ^ gf_xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ gf_xtime(a2) ^ gf_xtime(a3) ^ a3,
                gf_xtime(a0) ^ a0 ^ a1 ^ a2 ^ gf_xtime(a3)};
    endfunction

    // (3 - col_sel) * 32, col 0 is the msb word
    assign col_base = {~col_sel, {$clog2(`AES_WORD_W){1'b0}}};

    aes_sbox_word u_sbox (
        .word_in  (state_q[col_base +: `AES_WORD_W]),
        .word_out (col_sub)
    );

    always_comb begin
        shifted = shift_rows(state_q);
        for (int c = 0; c < `AES_NUM_WORDS; c++) begin
            mixed[c*`AES_WORD_W +: `AES_WORD_W] =
                mix_word(shifted[c*`AES_WORD_W +: `AES_WORD_W]);
        end
        add_in = final_round ? shifted : mixed;  // no mix in round 10
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (load) begin
            state_q <= plaintext ^ key;     // initial add round key
        end else if (sub_en) begin
            state_q[col_base +: `AES_WORD_W] <= col_sub;
        end else if (add_en) begin
            state_q <= add_in ^ round_key;
        end
    end

    assign state = state_q;                 // ciphertext once ack is up

endmodule

//--- hdl/aes_round_seq.sv
// round sequencer of the aes-128 core
// four-phase req/ack, round and column counters, datapath strobes
`timescale 1ns/1ns
`include "aes_consts.svh"

module aes_round_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    output logic                   ack,
    output logic                   load,
    output logic                   sub_en,
    output aes_ctrl_pkg::col_sel_t col_sel,
    output logic                   add_en,
    output logic                   final_round,
    output logic                   key_step
);
    import aes_data_pkg::*;
    import aes_ctrl_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;
    col_sel_t   col_q;                      // column in the sub pass
    aes_round_t round_q;                    // 1..10 while busy
    logic       last_col;
    logic       last_round;

    assign last_col   = (col_q == col_sel_t'(`AES_NUM_WORDS - 1));
    assign last_round = (round_q == aes_round_t'(`AES_NUM_ROUNDS));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req) begin
                    state_d = SUB;          // accepting edge
                end
            end
            SUB: begin
                if (last_col) begin
                    state_d = ADD;
                end
            end
            ADD:  state_d = last_round ? DONE : SUB;
            DONE: begin
                if (!req) begin
                    state_d = IDLE;         // ack falls with this edge
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            col_q   <= '0;
            round_q <= '0;
        end else begin
            state_q <= state_d;
            if (load) begin
                col_q   <= '0;
                round_q <= aes_round_t'(1);
            end else if (sub_en) begin
                col_q <= col_q + 1'b1;      // wraps to 0 after col 3
            end
            if (add_en && !last_round) begin
                round_q <= round_q + 1'b1;
            end
        end
    end

    // strobes decoded from state
    assign load        = (state_q == IDLE) && req;
    assign sub_en      = (state_q == SUB);
    assign col_sel     = col_q;
    assign add_en      = (state_q == ADD);
    assign final_round = add_en && last_round;   // skip mix columns
    assign key_step    = sub_en && (col_q == '0);  // key ready before ADD
    assign ack         = (state_q == DONE);

endmodule

//--- hdl/aes128_enc.sv
// aes-128 encipher core top level
// sequencer, round datapath and key schedule wired together
`timescale 1ns/1ns

module aes128_enc (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  aes_data_pkg::aes_block_t key,
    input  aes_data_pkg::aes_block_t plaintext,
    output logic                     ack,
    output aes_data_pkg::aes_block_t ciphertext,
    output aes_data_pkg::aes_block_t last_key
);
    import aes_ctrl_pkg::*;

    logic     load;                         // accept strobe
    logic     sub_en;
    col_sel_t col_sel;
    logic     add_en;
    logic     final_round;
    logic     key_step;

    aes_round_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .ack         (ack),
        .load        (load),
        .sub_en      (sub_en),
        .col_sel     (col_sel),
        .add_en      (add_en),
        .final_round (final_round),
        .key_step    (key_step)
    );

    aes_round_datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .plaintext   (plaintext),
        .key         (key),
        .sub_en      (sub_en),
        .col_sel     (col_sel),
        .add_en      (add_en),
        .final_round (final_round),
        .round_key   (last_key),            // live round key, final after round 10
        .state       (ciphertext)
    );

    aes_key_schedule u_key_sched (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .key       (key),
        .key_step  (key_step),
        .round_key (last_key)
    );

endmodule

//--- dv/aes128_enc_assert.sv
// handshake and output stability assertions for aes128_enc
// bound into every instance of the core
`timescale 1ns/1ns

module aes128_enc_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     req,
    input logic                     ack,
    input aes_data_pkg::aes_block_t ciphertext
);

    int fail_cnt = 0;                       // failed assertions so far

    // ack only answers a request
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req)
    ) else begin
        fail_cnt++;
        $error("ack rose without a preceding req");
    end

    // four-phase, ack drops only after req
    a_ack_holds: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req)
    ) else begin
        fail_cnt++;
        $error("ack fell while req was still high");
    end

    // result frozen while acknowledged
    a_ct_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> $stable(ciphertext)
    ) else begin
        fail_cnt++;
        $error("ciphertext changed while ack was high");
    end

    a_ack_low_after_rst: assert property (
        @(posedge clk)
        $rose(rst_n) |-> !ack
    ) else begin
        fail_cnt++;
        $error("ack high right after reset release");
    end

endmodule

bind aes128_enc aes128_enc_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ack        (ack),
    .ciphertext (ciphertext)
);

//--- dv/aes128_enc_tb.sv
// testbench for the aes-128 encipher core
// fips-197 vector table, four-phase request loop, checks and timeout
`timescale 1ns/1ns
`include "aes_consts.svh"

module aes128_enc_tb;
    import aes_data_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 5;
    localparam int RAND_SEED  = 66026;
    localparam int NUM_ROWS   = 3;
    localparam int NUM_PASSES = 4;          // ordered and shuffled, before and after reset
    localparam int MAX_GAP    = 7;
    localparam int MAX_HOLD   = 5;
    localparam int LATENCY    = `AES_NUM_ROUNDS * (`AES_NUM_WORDS + 1);
    localparam int TIMEOUT_CYCLES = NUM_PASSES * NUM_ROWS * (LATENCY + MAX_GAP + MAX_HOLD + 10)
                                  + 4 * RST_CYCLES;

    logic       clk;
    logic       rst_n;
    logic       req;
    aes_block_t key;
    aes_block_t plaintext;
    logic       ack;
    aes_block_t ciphertext;
    aes_block_t last_key;

    aes_block_t  tbl_key [NUM_ROWS];        // cipher key
    aes_block_t  tbl_pt  [NUM_ROWS];        // plaintext
    aes_block_t  tbl_ct  [NUM_ROWS];        // expected ciphertext
    aes_block_t  tbl_lk  [NUM_ROWS];        // expected round 10 key
    int          order   [NUM_ROWS];
    int          err_cnt;
    int          chk_cnt;
    int          cycle_cnt;
    int          cur_pass;

    aes128_enc uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .key        (key),
        .plaintext  (plaintext),
        .ack        (ack),
        .ciphertext (ciphertext),
        .last_key   (last_key)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fips-197 appendix b and c.1, plus the all-zero block
    task automatic fill_table();
        tbl_key[0] = 128'h000102030405060708090a0b0c0d0e0f;
        tbl_pt[0]  = 128'h00112233445566778899aabbccddeeff;
        tbl_ct[0]  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        tbl_lk[0]  = 128'h13111d7fe3944a17f307a78b4d2b30c5;
        tbl_key[1] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        tbl_pt[1]  = 128'h3243f6a8885a308d313198a2e0370734;
        tbl_ct[1]  = 128'h3925841d02dc09fbdc118597196a0b32;
        tbl_lk[1]  = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;
        tbl_key[2] = '0;
        tbl_pt[2]  = '0;
        tbl_ct[2]  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
        tbl_lk[2]  = 128'hb4ef5bcb3e92e21123e951cf6f8f188e;
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // idle cycles with junk on the data inputs
    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            key       <= {$urandom, $urandom, $urandom, $urandom};
            plaintext <= {$urandom, $urandom, $urandom, $urandom};
        end
    endtask

    task automatic run_transaction(input int row, input int hold);
        int    lows;
        int    n;
        string tag;
        tag = $sformatf("pass%0d row%0d", cur_pass, row);
        @(posedge clk);
        req       <= 1'b1;
        key       <= tbl_key[row];
        plaintext <= tbl_pt[row];
        lows = 0;
        @(negedge clk);
        while (!ack) begin
            lows++;
            @(negedge clk);
        end
        check_value({tag, " latency"}, LATENCY, lows - 1);  // minus the setup cycle
        check_value({tag, " ciphertext"}, tbl_ct[row], ciphertext);
        check_value({tag, " last_key"}, tbl_lk[row], last_key);
        for (int h = 0; h < hold; h++) begin  // back-pressure, req kept high
            @(negedge clk);
            check_value({tag, " ack held"}, 1, ack);
            check_value({tag, " ciphertext held"}, tbl_ct[row], ciphertext);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        n = 1;
        while (ack && n < 2) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            err_cnt++;
            $display("%s: ack still high two cycles after req was dropped", tag);
        end
    endtask

    task automatic run_set(input bit shuffle);
        int j;
        int tmp;
        for (int i = 0; i < NUM_ROWS; i++) begin
            order[i] = i;
        end
        if (shuffle) begin
            for (int i = NUM_ROWS - 1; i > 0; i--) begin
                j = $urandom_range(i, 0);
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            idle_gap($urandom_range(MAX_GAP, 0));
            run_transaction(order[i], $urandom_range(MAX_HOLD, 1));
        end
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("ack after reset", 0, ack);
        check_value("state after reset", '0, ciphertext);
        check_value("round key after reset", '0, last_key);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles without finishing", cycle_cnt);
            $display("checks %0d, errors %0d", chk_cnt, err_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(RAND_SEED));
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        key       = '0;
        plaintext = '0;
        err_cnt   = 0;
        chk_cnt   = 0;
        cycle_cnt = 0;
        cur_pass  = 0;
        fill_table();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("ack after power-up", 0, ack);
        run_set(1'b0);
        cur_pass = 1;
        run_set(1'b1);                      // random order
        pulse_reset();                      // while idle
        cur_pass = 2;
        run_set(1'b0);
        cur_pass = 3;
        run_set(1'b1);
        repeat (2) @(posedge clk);
        err_cnt += uut.u_assert.fail_cnt;   // handshake assertion failures
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/aes_data_pkg.sv
hdl/aes_ctrl_pkg.sv
hdl/aes_sbox_word.sv
hdl/aes_key_schedule.sv
hdl/aes_round_datapath.sv
hdl/aes_round_seq.sv
hdl/aes128_enc.sv
dv/aes128_enc_assert.sv
dv/aes128_enc_tb.sv

//--- Bender.yml
package:
  name: aes128_enc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aes_data_pkg.sv
      - hdl/aes_ctrl_pkg.sv
      - hdl/aes_sbox_word.sv
      - hdl/aes_key_schedule.sv
      - hdl/aes_round_datapath.sv
      - hdl/aes_round_seq.sv
      - hdl/aes128_enc.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/aes128_enc_assert.sv
      - dv/aes128_enc_tb.sv
